// File: idct_block.f
logic/idct_pkg.sv
logic/block_ram.sv
logic/mac_quad.sv
logic/idct_ctrl.sv
logic/idct_block.sv
tb/idct_block_chk.sv
tb/idct_block_tb.sv

// File: logic/block_ram.sv
`timescale 1ns/10ps
`default_nettype none

// single write port, two registered read ports, read latency 1
module block_ram #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_LOG2 = 6
) (
    input  logic                  CLOCK,
    input  idct_pkg::ram_wr_t     wr,
    input  logic [DEPTH_LOG2-1:0] rd_addr_a,
    input  logic [DEPTH_LOG2-1:0] rd_addr_b,
    output logic [WIDTH-1:0]      rd_a,
    output logic [WIDTH-1:0]      rd_b
);

    logic [WIDTH-1:0] mem [2**DEPTH_LOG2];

    always_ff @(posedge CLOCK) begin
        if (wr.enable) begin
            mem[wr.address] <= wr.data;
        end
    end

    // old data is returned on a same-address collision
    always_ff @(posedge CLOCK) begin
        rd_a <= mem[rd_addr_a];
        rd_b <= mem[rd_addr_b];
    end

endmodule

`default_nettype wire

// File: logic/idct_block.sv
`timescale 1ns/10ps
`default_nettype none

module idct_block (
    input  logic                             CLOCK,
    input  logic                             Resetn,
    input  logic                             in_valid,
    input  logic [idct_pkg::SAMPLE_W-1:0]    in_data,
    output logic                             in_ready,
    output logic                             out_valid,
    output logic [idct_pkg::ACC_W-1:0]       out_data,
    input  logic                             out_ready
);

    idct_pkg::ram_wr_t                buf_s_wr;
    idct_pkg::ram_wr_t                buf_t_wr;
    logic [idct_pkg::ADDR_W-1:0]      s_rd_addr_a;
    logic [idct_pkg::ADDR_W-1:0]      s_rd_addr_b;
    logic [idct_pkg::ADDR_W-1:0]      t_rd_addr_a;
    logic [idct_pkg::ADDR_W-1:0]      t_rd_addr_b;
    logic [idct_pkg::ACC_W-1:0]       s_rd_a;
    logic [idct_pkg::ACC_W-1:0]       s_rd_b;
    logic [idct_pkg::ACC_W-1:0]       t_rd_a;
    logic [idct_pkg::ACC_W-1:0]       t_rd_b;
    idct_pkg::mac_cmd_t               mac_cmd;
    logic                             pass;
    logic                             tile_done;
    idct_pkg::quad_sum_t              tile_sum;

    idct_ctrl ctrl_i (
        .CLOCK       (CLOCK),
        .Resetn      (Resetn),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_ready   (out_ready),
        .buf_s_wr    (buf_s_wr),
        .buf_t_wr    (buf_t_wr),
        .s_rd_addr_a (s_rd_addr_a),
        .s_rd_addr_b (s_rd_addr_b),
        .t_rd_addr_a (t_rd_addr_a),
        .t_rd_addr_b (t_rd_addr_b),
        .s_rd_a      (s_rd_a),
        .mac_cmd     (mac_cmd),
        .pass        (pass),
        .tile_done   (tile_done),
        .tile_sum    (tile_sum)
    );

    // coefficients in, final S out
    block_ram #(
        .WIDTH      (idct_pkg::ACC_W),
        .DEPTH_LOG2 (idct_pkg::ADDR_W)
    ) buf_s_i (
        .CLOCK     (CLOCK),
        .wr        (buf_s_wr),
        .rd_addr_a (s_rd_addr_a),
        .rd_addr_b (s_rd_addr_b),
        .rd_a      (s_rd_a),
        .rd_b      (s_rd_b)
    );

    // intermediate T, stored transposed
    block_ram #(
        .WIDTH      (idct_pkg::ACC_W),
        .DEPTH_LOG2 (idct_pkg::ADDR_W)
    ) buf_t_i (
        .CLOCK     (CLOCK),
        .wr        (buf_t_wr),
        .rd_addr_a (t_rd_addr_a),
        .rd_addr_b (t_rd_addr_b),
        .rd_a      (t_rd_a),
        .rd_b      (t_rd_b)
    );

    mac_quad mac_i (
        .CLOCK     (CLOCK),
        .Resetn    (Resetn),
        .cmd       (mac_cmd),
        .pass      (pass),
        .s_rd_a    (s_rd_a),
        .s_rd_b    (s_rd_b),
        .t_rd_a    (t_rd_a),
        .t_rd_b    (t_rd_b),
        .tile_done (tile_done),
        .tile_sum  (tile_sum)
    );

endmodule

`default_nettype wire

// File: logic/idct_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module idct_ctrl (
    input  logic                             CLOCK,
    input  logic                             Resetn,
    input  logic                             in_valid,
    input  logic [idct_pkg::SAMPLE_W-1:0]    in_data,
    output logic                             in_ready,
    output logic                             out_valid,
    output logic [idct_pkg::ACC_W-1:0]       out_data,
    input  logic                             out_ready,
    output idct_pkg::ram_wr_t                buf_s_wr,
    output idct_pkg::ram_wr_t                buf_t_wr,
    output logic [idct_pkg::ADDR_W-1:0]      s_rd_addr_a,
    output logic [idct_pkg::ADDR_W-1:0]      s_rd_addr_b,
    output logic [idct_pkg::ADDR_W-1:0]      t_rd_addr_a,
    output logic [idct_pkg::ADDR_W-1:0]      t_rd_addr_b,
    input  logic [idct_pkg::ACC_W-1:0]       s_rd_a,
    output idct_pkg::mac_cmd_t               mac_cmd,
    output logic                             pass,
    input  logic                             tile_done,
    input  idct_pkg::quad_sum_t              tile_sum
);

    idct_pkg::ctrl_state_e              state;
    logic [idct_pkg::ADDR_W-1:0]        cnt;       // load / unload word index
    logic [1:0]                         row_pair;  // tile rows 2*row_pair, +1
    logic [1:0]                         col_pair;
    logic [2:0]                         k;
    logic                               issue;     // k steps going out
    logic                               wb_busy;
    logic [1:0]                         wb_idx;    // aa, ab, ba, bb
    logic [1:0]                         fetch;     // unload read pipeline
    logic [idct_pkg::ADDR_W-1:0]        row_addr_a;
    logic [idct_pkg::ADDR_W-1:0]        row_addr_b;
    logic [idct_pkg::ADDR_W-1:0]        wb_addr;
    logic [idct_pkg::ACC_W-1:0]         wb_data;
    logic                               last_word;
    logic                               last_tile;

    assign last_word = (cnt == idct_pkg::ADDR_W'(idct_pkg::N_COEF - 1));
    assign last_tile = (row_pair == 2'd3) && (col_pair == 2'd3);

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            state     <= idct_pkg::ST_LOAD;
            cnt       <= '0;
            row_pair  <= '0;
            col_pair  <= '0;
            k         <= '0;
            issue     <= 1'b0;
            wb_busy   <= 1'b0;
            wb_idx    <= '0;
            fetch     <= '0;
            out_valid <= 1'b0;
        end else begin
            case (state)
                idct_pkg::ST_LOAD: begin
                    if (in_valid) begin
                        cnt <= cnt + 1'b1;  // wraps to 0 after the last word
                        if (last_word) begin
                            state <= idct_pkg::ST_PASS1;
                            issue <= 1'b1;
                        end
                    end
                end
                idct_pkg::ST_PASS1, idct_pkg::ST_PASS2: begin
                    if (issue) begin
                        k <= k + 1'b1;
                        if (k == 3'(idct_pkg::N_DIM - 1)) begin
                            issue <= 1'b0;
                        end
                    end
                    if (tile_done) begin
                        wb_busy <= 1'b1;
                        wb_idx  <= '0;
                    end
                    if (wb_busy) begin
                        wb_idx <= wb_idx + 1'b1;
                        if (wb_idx == 2'd3) begin
                            wb_busy  <= 1'b0;
                            col_pair <= col_pair + 1'b1;
                            if (col_pair == 2'd3) begin
                                row_pair <= row_pair + 1'b1;
                            end
                            if (!last_tile) begin
                                issue <= 1'b1;
                            end else if (state == idct_pkg::ST_PASS1) begin
                                state <= idct_pkg::ST_PASS2;
                                issue <= 1'b1;
                            end else begin
                                state <= idct_pkg::ST_UNLOAD;
                                fetch <= 2'b01;
                            end
                        end
                    end
                end
                idct_pkg::ST_UNLOAD: begin
                    fetch <= {fetch[0], 1'b0};
                    if (fetch[1]) begin
                        out_valid <= 1'b1;
                    end
                    if (out_valid && out_ready) begin
                        out_valid <= 1'b0;
                        cnt       <= cnt + 1'b1;
                        if (last_word) begin
                            state <= idct_pkg::ST_LOAD;
                        end else begin
                            fetch <= 2'b01;
                        end
                    end
                end
                default: state <= idct_pkg::ST_LOAD;
            endcase
        end
    end

    // output holding register, stable under back-pressure
    always_ff @(posedge CLOCK) begin
        if (state == idct_pkg::ST_UNLOAD && fetch[1]) begin
            out_data <= s_rd_a;
        end
    end

    assign in_ready = (state == idct_pkg::ST_LOAD);
    assign pass     = (state == idct_pkg::ST_PASS2);

    assign row_addr_a = {row_pair, 1'b0, k};  // element (r, k)
    assign row_addr_b = {row_pair, 1'b1, k};  // element (r+1, k)

    // results go out transposed: column index becomes the row
    assign wb_addr = {col_pair, wb_idx[0], row_pair, wb_idx[1]};

    always_comb begin
        case (wb_idx)
            2'd0:    wb_data = tile_sum.aa;
            2'd1:    wb_data = tile_sum.ab;
            2'd2:    wb_data = tile_sum.ba;
            default: wb_data = tile_sum.bb;
        endcase
    end

    assign s_rd_addr_a = (state == idct_pkg::ST_UNLOAD) ? cnt : row_addr_a;
    assign s_rd_addr_b = row_addr_b;
    assign t_rd_addr_a = row_addr_a;
    assign t_rd_addr_b = row_addr_b;

    assign mac_cmd.step  = issue;
    assign mac_cmd.first = (k == 3'd0);
    assign mac_cmd.k     = k;
    assign mac_cmd.pair  = col_pair;

    always_comb begin
        buf_s_wr = '0;
        if (state == idct_pkg::ST_LOAD) begin
            buf_s_wr.enable  = in_valid;
            buf_s_wr.address = cnt;
            buf_s_wr.data    = {{(idct_pkg::ACC_W - idct_pkg::SAMPLE_W){in_data[idct_pkg::SAMPLE_W-1]}},
                                in_data};
        end else if (state == idct_pkg::ST_PASS2) begin
            buf_s_wr.enable  = wb_busy;  // final S, row-major
            buf_s_wr.address = wb_addr;
            buf_s_wr.data    = wb_data;
        end
    end

    assign buf_t_wr.enable  = wb_busy && (state == idct_pkg::ST_PASS1);
    assign buf_t_wr.address = wb_addr;
    assign buf_t_wr.data    = wb_data;

endmodule

`default_nettype wire

// File: logic/idct_pkg.sv
`default_nettype none

package idct_pkg;

    localparam int N_DIM      = 8;   // block side
    localparam int N_COEF     = 64;  // coefficients per block
    localparam int ADDR_W     = 6;
    localparam int SAMPLE_W   = 16;  // input coefficient width
    localparam int ACC_W      = 32;  // buffer, accumulator and output width
    localparam int COS_W      = 13;
    localparam int PROD_SHIFT = 8;   // applied to every product before the sum

    // C[k][j], row 0 is the scaled 1/sqrt(2) term
    localparam logic signed [COS_W-1:0] cos_table [N_DIM][N_DIM] = '{
        '{ 13'sd362,  13'sd362,  13'sd362,  13'sd362,
           13'sd362,  13'sd362,  13'sd362,  13'sd362},
        '{ 13'sd502,  13'sd426,  13'sd284,  13'sd100,
          -13'sd100, -13'sd284, -13'sd426, -13'sd502},
        '{ 13'sd473,  13'sd196, -13'sd196, -13'sd473,
          -13'sd473, -13'sd196,  13'sd196,  13'sd473},
        '{ 13'sd426, -13'sd100, -13'sd502, -13'sd284,
           13'sd284,  13'sd502,  13'sd100, -13'sd426},
        '{ 13'sd362, -13'sd362, -13'sd362,  13'sd362,
           13'sd362, -13'sd362, -13'sd362,  13'sd362},
        '{ 13'sd284, -13'sd502,  13'sd100,  13'sd426,
          -13'sd426, -13'sd100,  13'sd502, -13'sd284},
        '{ 13'sd196, -13'sd473,  13'sd473, -13'sd196,
          -13'sd196,  13'sd473, -13'sd473,  13'sd196},
        '{ 13'sd100, -13'sd284,  13'sd426, -13'sd502,
           13'sd502, -13'sd426,  13'sd284, -13'sd100}
    };

    typedef enum logic [1:0] {
        ST_LOAD   = 2'd0,  // filling buf_s from the input stream
        ST_PASS1  = 2'd1,  // buf_s -> buf_t
        ST_PASS2  = 2'd2,  // buf_t -> buf_s
        ST_UNLOAD = 2'd3   // draining buf_s to the output stream
    } ctrl_state_e;

    typedef struct packed {
        logic              enable;
        logic [ADDR_W-1:0] address;
        logic [ACC_W-1:0]  data;
    } ram_wr_t;

    // one k step of a 2x2 tile
    typedef struct packed {
        logic       step;   // valid step this cycle
        logic       first;  // k == 0, restart sums
        logic [2:0] k;
        logic [1:0] pair;   // column pair, columns 2p and 2p+1
    } mac_cmd_t;

    typedef struct packed {
        logic signed [ACC_W-1:0] aa;  // row r,   col 2p
        logic signed [ACC_W-1:0] ab;  // row r,   col 2p+1
        logic signed [ACC_W-1:0] ba;  // row r+1, col 2p
        logic signed [ACC_W-1:0] bb;  // row r+1, col 2p+1
    } quad_sum_t;

endpackage

`default_nettype wire

// File: logic/mac_quad.sv
`timescale 1ns/10ps
`default_nettype none

module mac_quad (
    input  logic                          CLOCK,
    input  logic                          Resetn,
    input  idct_pkg::mac_cmd_t            cmd,
    input  logic                          pass,
    input  logic [idct_pkg::ACC_W-1:0]    s_rd_a,
    input  logic [idct_pkg::ACC_W-1:0]    s_rd_b,
    input  logic [idct_pkg::ACC_W-1:0]    t_rd_a,
    input  logic [idct_pkg::ACC_W-1:0]    t_rd_b,
    output logic                          tile_done,
    output idct_pkg::quad_sum_t           tile_sum
);

    idct_pkg::mac_cmd_t                  cmd_q;   // lines up with read data
    idct_pkg::mac_cmd_t                  cmd_q2;  // lines up with product register
    logic                                pass_q;
    logic signed [idct_pkg::ACC_W-1:0]   op_a;
    logic signed [idct_pkg::ACC_W-1:0]   op_b;
    logic signed [idct_pkg::COS_W-1:0]   cos_0;
    logic signed [idct_pkg::COS_W-1:0]   cos_1;
    idct_pkg::quad_sum_t                 prod_q;
    idct_pkg::quad_sum_t                 acc;

    // 32-bit wrapped product, then arithmetic shift
    function automatic logic signed [idct_pkg::ACC_W-1:0] scaled(
        input logic signed [idct_pkg::ACC_W-1:0] x,
        input logic signed [idct_pkg::COS_W-1:0] c
    );
        logic signed [idct_pkg::ACC_W-1:0] p;
        p = x * c;
        return p >>> idct_pkg::PROD_SHIFT;
    endfunction

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            cmd_q     <= '0;
            cmd_q2    <= '0;
            pass_q    <= 1'b0;
            tile_done <= 1'b0;
        end else begin
            cmd_q     <= cmd;
            cmd_q2    <= cmd_q;
            pass_q    <= pass;
            tile_done <= cmd_q2.step && (cmd_q2.k == 3'(idct_pkg::N_DIM - 1));
        end
    end

    assign op_a  = $signed(pass_q ? t_rd_a : s_rd_a);  // row r
    assign op_b  = $signed(pass_q ? t_rd_b : s_rd_b);  // row r+1
    assign cos_0 = idct_pkg::cos_table[cmd_q.k][{cmd_q.pair, 1'b0}];
    assign cos_1 = idct_pkg::cos_table[cmd_q.k][{cmd_q.pair, 1'b1}];

    always_ff @(posedge CLOCK) begin
        prod_q.aa <= scaled(op_a, cos_0);
        prod_q.ab <= scaled(op_a, cos_1);
        prod_q.ba <= scaled(op_b, cos_0);
        prod_q.bb <= scaled(op_b, cos_1);
    end

    always_ff @(posedge CLOCK) begin
        if (cmd_q2.step) begin
            if (cmd_q2.first) begin
                acc <= prod_q;
            end else begin
                acc.aa <= acc.aa + prod_q.aa;
                acc.ab <= acc.ab + prod_q.ab;
                acc.ba <= acc.ba + prod_q.ba;
                acc.bb <= acc.bb + prod_q.bb;
            end
        end
    end

    assign tile_sum = acc;  // held until the next tile starts

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the idct_block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module idct_block_tb -f idct_block.f
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vidct_block_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi

// File: tb/idct_block_chk.sv
`timescale 1ns/10ps
`default_nettype none

module idct_block_chk (
    input logic                        CLOCK,
    input logic                        Resetn,
    input logic                        in_ready,
    input logic                        out_valid,
    input logic                        out_ready,
    input logic [idct_pkg::ACC_W-1:0]  out_data,
    input idct_pkg::ctrl_state_e       state
);

    // a stalled word stays on the bus unchanged
    hold_a: assert property (@(posedge CLOCK) disable iff (!Resetn)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_valid dropped or out_data changed while out_ready was low");

    // loading and unloading never overlap
    excl_a: assert property (@(posedge CLOCK) disable iff (!Resetn)
        !(in_ready && out_valid))
        else $error("in_ready and out_valid are high together");

    // FSM order is load then pass 1 then pass 2 then unload
    state_a: assert property (@(posedge CLOCK) disable iff (!Resetn)
        $changed(state) |->
            ($past(state) == idct_pkg::ST_LOAD   && state == idct_pkg::ST_PASS1)  ||
            ($past(state) == idct_pkg::ST_PASS1  && state == idct_pkg::ST_PASS2)  ||
            ($past(state) == idct_pkg::ST_PASS2  && state == idct_pkg::ST_UNLOAD) ||
            ($past(state) == idct_pkg::ST_UNLOAD && state == idct_pkg::ST_LOAD))
        else $error("controller state moved to an illegal next state");

endmodule

`default_nettype wire

// File: tb/idct_block_tb.sv
`timescale 1ns/10ps
`default_nettype none

module idct_block_tb;

    localparam int NUM_BLOCKS      = 8;
    localparam int WATCHDOG_CYCLES = 5000 * NUM_BLOCKS;

    logic                                  CLOCK = 1'b0;
    logic                                  Resetn;
    logic                                  in_valid;
    logic [idct_pkg::SAMPLE_W-1:0]         in_data;
    logic                                  in_ready;
    logic                                  out_valid;
    logic [idct_pkg::ACC_W-1:0]            out_data;
    logic                                  out_ready;

    logic signed [idct_pkg::SAMPLE_W-1:0]  coefs [NUM_BLOCKS * idct_pkg::N_COEF];
    logic                                  in_gaps [NUM_BLOCKS];     // idle cycles while loading
    logic                                  out_stalls [NUM_BLOCKS];  // random out_ready
    int                                    errors = 0;
    int                                    in_xfers = 0;
    int                                    out_xfers = 0;
    logic                                  ready_exp;

    idct_block dut_i (
        .CLOCK     (CLOCK),
        .Resetn    (Resetn),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    bind idct_ctrl idct_block_chk chk_i (
        .CLOCK     (CLOCK),
        .Resetn    (Resetn),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .state     (state)
    );

    always #20 CLOCK = ~CLOCK;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %0d, expected %0d",
                     $time, what, $signed(got), $signed(exp));
            $display("Done: errors found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // product wrapped to 32 bits, then arithmetic shift
    function automatic logic signed [31:0] shifted_product(input logic signed [31:0] x,
                                                           input logic signed [12:0] c);
        longint             full;
        logic signed [31:0] low;
        full = longint'(x) * longint'(c);
        low  = full[31:0];
        return low >>> idct_pkg::PROD_SHIFT;
    endfunction

    // S[row][col] = sum_k (T[k][col] * C[k][row]) >>> 8
    // T = X * C with the same shift per product
    function automatic logic signed [31:0] expected_word(input int blk, input int idx);
        logic signed [31:0] t_col [idct_pkg::N_DIM];
        logic signed [31:0] x;
        logic signed [31:0] sum;
        int                 row;
        int                 col;
        int                 base;
        int                 k;
        int                 n;
        row  = idx / idct_pkg::N_DIM;
        col  = idx % idct_pkg::N_DIM;
        base = blk * idct_pkg::N_COEF;
        for (k = 0; k < idct_pkg::N_DIM; k++) begin
            sum = 0;
            for (n = 0; n < idct_pkg::N_DIM; n++) begin
                x   = coefs[base + k * idct_pkg::N_DIM + n];  // sign extended
                sum = sum + shifted_product(x, idct_pkg::cos_table[n][col]);
            end
            t_col[k] = sum;
        end
        sum = 0;
        for (k = 0; k < idct_pkg::N_DIM; k++) begin
            sum = sum + shifted_product(t_col[k], idct_pkg::cos_table[k][row]);
        end
        return sum;
    endfunction

    task automatic make_blocks();
        int b;
        int i;
        int val;
        for (b = 0; b < NUM_BLOCKS; b++) begin
            in_gaps[b]    = (b == 3) || (b >= 5);
            out_stalls[b] = (b == 4) || (b >= 5);
            for (i = 0; i < idct_pkg::N_COEF; i++) begin
                if (b == 0) begin
                    coefs[i] = (i == 0) ? 16'sd800 : 16'sd0;  // DC only
                end else begin
                    val = int'($urandom % 2048) - 1024;
                    coefs[b * idct_pkg::N_COEF + i] = 16'(val);
                end
            end
        end
    endtask

    task automatic send_word(input logic [idct_pkg::SAMPLE_W-1:0] data, input logic gaps);
        int   idle;
        logic taken;
        idle     = gaps ? int'($urandom % 4) : 0;
        in_valid = 1'b0;
        repeat (idle) begin
            @(posedge CLOCK);
            #2;
        end
        in_valid = 1'b1;
        in_data  = data;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge CLOCK);
            taken = in_ready;  // transfer on the coming edge
            @(posedge CLOCK);
            #2;
        end
        in_valid = 1'b0;
    endtask

    task automatic receive_word(input logic stalls, output logic [idct_pkg::ACC_W-1:0] data);
        logic got;
        got = 1'b0;
        while (!got) begin
            out_ready = stalls ? (($urandom % 3) != 0) : 1'b1;
            @(negedge CLOCK);
            if (out_valid && out_ready) begin
                data = out_data;
                got  = 1'b1;
            end
            @(posedge CLOCK);
            #2;
        end
        out_ready = 1'b0;
    endtask

    task automatic drive_blocks();
        int b;
        int i;
        for (b = 0; b < NUM_BLOCKS; b++) begin
            for (i = 0; i < idct_pkg::N_COEF; i++) begin
                send_word(coefs[b * idct_pkg::N_COEF + i], in_gaps[b]);
            end
        end
    endtask

    task automatic collect_blocks();
        int                         b;
        int                         i;
        logic [idct_pkg::ACC_W-1:0] word;
        for (b = 0; b < NUM_BLOCKS; b++) begin
            for (i = 0; i < idct_pkg::N_COEF; i++) begin
                receive_word(out_stalls[b], word);
                check_value(word, expected_word(b, i),
                            $sformatf("block %0d word %0d", b, i));
            end
        end
    endtask

    // ready only while a block is partly loaded or everything sent has come back
    assign ready_exp = ((in_xfers % idct_pkg::N_COEF) != 0) || (out_xfers == in_xfers);

    always @(negedge CLOCK) begin
        if (Resetn) begin
            check_value(32'(in_ready), 32'(ready_exp), "in_ready");
            if (in_valid && in_ready) begin
                in_xfers++;
            end
            if (out_valid && out_ready) begin
                out_xfers++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLOCK);
        $display("timeout: the blocks did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(42));
        Resetn    = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        make_blocks();
        repeat (3) @(posedge CLOCK);
        #2;
        Resetn = 1'b1;
        @(negedge CLOCK);
        check_value(32'(in_ready), 32'd1, "in_ready after reset");
        check_value(32'(out_valid), 32'd0, "out_valid after reset");
        @(posedge CLOCK);
        #2;
        fork
            drive_blocks();
            collect_blocks();
        join
        // no extra word may follow the last block
        repeat (4) begin
            @(negedge CLOCK);
            check_value(32'(out_valid), 32'd0, "out_valid after the last block");
        end
        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire
